/* logic/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// buffer geometry
`define ROB_DEPTH 32      // entries, power of two so pointers wrap on their own
`define ROB_LANES 3       // dispatch / complete / retire width

// datapath widths
`define XLEN 32           // result word
`define ARCH_REG_BITS 5   // architectural register index

`endif

/* logic/rob_pkg.sv */
`include "rob_params.svh"

package rob_pkg;

    // entry index doubles as the tag handed out at dispatch
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // free entry count, 0 up to full depth
    typedef logic [$clog2(`ROB_DEPTH):0] rob_count_t;

    // dispatch credits, capped at lane count
    typedef logic [$clog2(`ROB_LANES+1)-1:0] credit_t;

    typedef logic [`ARCH_REG_BITS-1:0] arch_reg_t;  // destination reg
    typedef logic [`XLEN-1:0] word_t;               // result value

    // coarse class, only memory vs not matters to the rob
    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } op_class_e;

    // one rob line, 42 bits
    typedef struct packed {
        logic      busy;        // allocated, not yet retired
        logic      done;        // result written back from cdb
        logic      dest_valid;  // writes a register
        arch_reg_t dest;
        logic      is_mem;      // load or store
        logic      taken;       // taken branch, reported at completion
        word_t     value;
    } rob_entry_t;

endpackage

/* logic/rob_ifs.sv */
`include "rob_params.svh"

// dispatch writes from allocator into the entry table
interface rob_alloc_if;

    logic [`ROB_LANES-1:0]                    wr_valid;       // prefix of lanes
    rob_pkg::rob_tag_t [`ROB_LANES-1:0]       wr_tag;         // tail, tail+1, tail+2
    rob_pkg::op_class_e [`ROB_LANES-1:0]      wr_op;
    logic [`ROB_LANES-1:0]                    wr_dest_valid;
    rob_pkg::arch_reg_t [`ROB_LANES-1:0]      wr_dest;
    rob_pkg::rob_count_t                      free_count;     // back from table

    modport alloc_side (
        output wr_valid,
        output wr_tag,
        output wr_op,
        output wr_dest_valid,
        output wr_dest,
        input  free_count
    );

    modport table_side (
        input  wr_valid,
        input  wr_tag,
        input  wr_op,
        input  wr_dest_valid,
        input  wr_dest,
        output free_count
    );

endinterface

// head window between retire logic and the table
interface rob_head_if;

    rob_pkg::rob_tag_t                        head_tag;
    logic [`ROB_LANES-1:0]                    retire_mask;    // lanes leaving this cycle
    rob_pkg::rob_entry_t [`ROB_LANES-1:0]     head_entry;     // entries at head..head+2

    modport retire_side (
        output head_tag,
        output retire_mask,
        input  head_entry
    );

    modport table_side (
        input  head_tag,
        input  retire_mask,
        output head_entry
    );

endinterface

/* logic/rob_alloc.sv */
`include "rob_params.svh"

module rob_alloc (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  squash,
    input  logic [`ROB_LANES-1:0]                 dispatch_valid,
    input  rob_pkg::op_class_e [`ROB_LANES-1:0]   dispatch_op,
    input  logic [`ROB_LANES-1:0]                 dispatch_dest_valid,
    input  rob_pkg::arch_reg_t [`ROB_LANES-1:0]   dispatch_dest,
    output rob_pkg::rob_tag_t [`ROB_LANES-1:0]    alloc_tag,
    output logic [`ROB_LANES-1:0]                 map_valid,
    output rob_pkg::credit_t                      credits,
    rob_alloc_if.alloc_side                       alloc
);

    rob_pkg::rob_tag_t tail_q;    // next free slot
    rob_pkg::credit_t  n_valid;   // lanes spent this cycle

    // consecutive tags from the tail, wrap is free since depth is 2^n
    for (genvar i = 0; i < `ROB_LANES; i++) begin : g_tag
        assign alloc_tag[i] = tail_q + rob_pkg::rob_tag_t'(i);
    end

    // map table only cares about lanes that name a register
    assign map_valid = dispatch_valid & dispatch_dest_valid;

    // lanes are a prefix, so a plain popcount gives the tail step
    always_comb begin
        n_valid = '0;
        for (int i = 0; i < `ROB_LANES; i++) begin
            n_valid = n_valid + rob_pkg::credit_t'(dispatch_valid[i]);
        end
    end

    // credits from registered free count, so they only move at the edge
    assign credits = (alloc.free_count > rob_pkg::rob_count_t'(`ROB_LANES))
                   ? rob_pkg::credit_t'(`ROB_LANES)
                   : rob_pkg::credit_t'(alloc.free_count);

    // table write port
    assign alloc.wr_valid      = dispatch_valid;
    assign alloc.wr_tag        = alloc_tag;
    assign alloc.wr_op         = dispatch_op;
    assign alloc.wr_dest_valid = dispatch_dest_valid;
    assign alloc.wr_dest       = dispatch_dest;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            tail_q <= '0;     // squash drops everything in flight
        end else begin
            tail_q <= tail_q + rob_pkg::rob_tag_t'(n_valid);
        end
    end

    // dispatcher may never leave a gap between lanes
    for (genvar i = 1; i < `ROB_LANES; i++) begin : g_prefix_chk
        a_dispatch_prefix : assert property (
            @(posedge clock) disable iff (reset)
            dispatch_valid[i] |-> dispatch_valid[i-1]
        );
    end

    // credit contract, credits come from the table's busy bits
    a_dispatch_credit : assert property (
        @(posedge clock) disable iff (reset || squash)
        n_valid <= credits
    );

endmodule

/* logic/rob_table.sv */
`include "rob_params.svh"

module rob_table (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  squash,
    input  rob_pkg::rob_tag_t [`ROB_LANES-1:0]    src_tag_a,
    input  rob_pkg::rob_tag_t [`ROB_LANES-1:0]    src_tag_b,
    output rob_pkg::word_t [`ROB_LANES-1:0]       src_value_a,
    output rob_pkg::word_t [`ROB_LANES-1:0]       src_value_b,
    output logic [`ROB_LANES-1:0]                 src_ready_a,
    output logic [`ROB_LANES-1:0]                 src_ready_b,
    input  logic [`ROB_LANES-1:0]                 complete_valid,
    input  rob_pkg::rob_tag_t [`ROB_LANES-1:0]    complete_tag,
    input  rob_pkg::word_t [`ROB_LANES-1:0]       complete_value,
    input  logic [`ROB_LANES-1:0]                 complete_taken,
    rob_alloc_if.table_side                       alloc,
    rob_head_if.table_side                        head
);

    // control bits, cleared by reset and squash
    logic [`ROB_DEPTH-1:0] busy_q;
    logic [`ROB_DEPTH-1:0] done_q;

    // payload, only meaningful while busy
    logic                 dest_valid_q [`ROB_DEPTH];
    rob_pkg::arch_reg_t   dest_q       [`ROB_DEPTH];
    logic                 is_mem_q     [`ROB_DEPTH];
    logic                 taken_q      [`ROB_DEPTH];
    rob_pkg::word_t       value_q      [`ROB_DEPTH];

    rob_pkg::rob_tag_t    head_slot    [`ROB_LANES];  // head window indices
    rob_pkg::rob_count_t  free_cnt;

    for (genvar i = 0; i < `ROB_LANES; i++) begin : g_slot
        assign head_slot[i] = head.head_tag + rob_pkg::rob_tag_t'(i);
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy_q <= '0;
            done_q <= '0;
        end else begin
            // retiring lines go free
            for (int i = 0; i < `ROB_LANES; i++) begin
                if (head.retire_mask[i]) begin
                    busy_q[head_slot[i]] <= 1'b0;
                    done_q[head_slot[i]] <= 1'b0;
                end
            end
            // new lines, never overlap a retiring one since credits see busy
            for (int i = 0; i < `ROB_LANES; i++) begin
                if (alloc.wr_valid[i]) begin
                    busy_q[alloc.wr_tag[i]] <= 1'b1;
                    done_q[alloc.wr_tag[i]] <= 1'b0;
                end
            end
            // cdb writeback
            for (int i = 0; i < `ROB_LANES; i++) begin
                if (complete_valid[i]) begin
                    done_q[complete_tag[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_LANES; i++) begin
            if (alloc.wr_valid[i]) begin
                dest_valid_q[alloc.wr_tag[i]] <= alloc.wr_dest_valid[i];
                dest_q[alloc.wr_tag[i]]       <= alloc.wr_dest[i];
                is_mem_q[alloc.wr_tag[i]]     <= (alloc.wr_op[i] == rob_pkg::OP_LOAD) ||
                                                 (alloc.wr_op[i] == rob_pkg::OP_STORE);
            end
            if (complete_valid[i]) begin
                value_q[complete_tag[i]] <= complete_value[i];
                taken_q[complete_tag[i]] <= complete_taken[i];  // branch outcome
            end
        end
    end

    // operand lookup for the reservation stations, no cdb bypass
    for (genvar i = 0; i < `ROB_LANES; i++) begin : g_src
        assign src_value_a[i] = value_q[src_tag_a[i]];
        assign src_value_b[i] = value_q[src_tag_b[i]];
        assign src_ready_a[i] = done_q[src_tag_a[i]];
        assign src_ready_b[i] = done_q[src_tag_b[i]];
    end

    // free slots, the allocator caps this into credits
    always_comb begin
        free_cnt = '0;
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            free_cnt = free_cnt + rob_pkg::rob_count_t'(!busy_q[k]);
        end
    end
    assign alloc.free_count = free_cnt;

    // head window view
    always_comb begin
        for (int i = 0; i < `ROB_LANES; i++) begin
            head.head_entry[i].busy       = busy_q[head_slot[i]];
            head.head_entry[i].done       = done_q[head_slot[i]];
            head.head_entry[i].dest_valid = dest_valid_q[head_slot[i]];
            head.head_entry[i].dest       = dest_q[head_slot[i]];
            head.head_entry[i].is_mem     = is_mem_q[head_slot[i]];
            head.head_entry[i].taken      = taken_q[head_slot[i]];
            head.head_entry[i].value      = value_q[head_slot[i]];
        end
    end

    // cdb may only complete something the allocator handed out
    for (genvar i = 0; i < `ROB_LANES; i++) begin : g_cmp_chk
        a_complete_live : assert property (
            @(posedge clock) disable iff (reset || squash)
            complete_valid[i] |-> busy_q[complete_tag[i]]
        );
    end

endmodule

/* logic/rob_retire.sv */
`include "rob_params.svh"

module rob_retire (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  squash,
    input  logic                                  mem_busy,
    output logic [`ROB_LANES-1:0]                 retire_valid,
    output rob_pkg::rob_tag_t [`ROB_LANES-1:0]    retire_tag,
    output logic [`ROB_LANES-1:0]                 retire_dest_valid,
    output rob_pkg::arch_reg_t [`ROB_LANES-1:0]   retire_dest,
    output rob_pkg::word_t [`ROB_LANES-1:0]       retire_value,
    output logic [`ROB_LANES-1:0]                 retire_taken,
    rob_head_if.retire_side                       head
);

    rob_pkg::rob_tag_t      head_q;               // oldest live entry
    logic [`ROB_LANES-1:0]  serial;               // mem op or taken branch
    logic [`ROB_LANES-1:0]  mem_before;           // a lower lane is mem
    logic [`ROB_LANES-1:0]  blocked;
    rob_pkg::credit_t       n_retire;

    assign head.head_tag = head_q;

    for (genvar i = 0; i < `ROB_LANES; i++) begin : g_lane
        assign serial[i] = head.head_entry[i].is_mem || head.head_entry[i].taken;

        // mem unit busy or an earlier mem op in this group holds it back
        assign blocked[i] = serial[i] && (mem_busy || mem_before[i]);

        // retire fields pass straight from the head entries
        assign retire_tag[i]        = head_q + rob_pkg::rob_tag_t'(i);
        assign retire_dest_valid[i] = head.head_entry[i].dest_valid;
        assign retire_dest[i]       = head.head_entry[i].dest;
        assign retire_value[i]      = head.head_entry[i].value;
        assign retire_taken[i]      = head.head_entry[i].taken;
    end

    // running or of is_mem below each lane
    always_comb begin
        mem_before[0] = 1'b0;
        for (int i = 1; i < `ROB_LANES; i++) begin
            mem_before[i] = mem_before[i-1] || head.head_entry[i-1].is_mem;
        end
    end

    // in order, a lane goes only if every older lane goes too
    always_comb begin
        retire_valid[0] = head.head_entry[0].busy && head.head_entry[0].done && !blocked[0];
        for (int i = 1; i < `ROB_LANES; i++) begin
            retire_valid[i] = retire_valid[i-1] && head.head_entry[i].busy &&
                              head.head_entry[i].done && !blocked[i];
        end
    end

    assign head.retire_mask = retire_valid;   // table frees these lines

    always_comb begin
        n_retire = '0;
        for (int i = 0; i < `ROB_LANES; i++) begin
            n_retire = n_retire + rob_pkg::credit_t'(retire_valid[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head_q <= '0;
        end else begin
            head_q <= head_q + rob_pkg::rob_tag_t'(n_retire);  // step by group size
        end
    end

    // live entries sit contiguous from the head, so window busy bits are a prefix
    for (genvar i = 1; i < `ROB_LANES; i++) begin : g_prefix_chk
        a_head_prefix : assert property (
            @(posedge clock) disable iff (reset)
            head.head_entry[i].busy |-> head.head_entry[i-1].busy
        );
    end

endmodule

/* logic/rob_top.sv */
`include "rob_params.svh"

module rob_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  squash,
    // dispatch
    input  logic [`ROB_LANES-1:0]                 dispatch_valid,
    input  rob_pkg::op_class_e [`ROB_LANES-1:0]   dispatch_op,
    input  logic [`ROB_LANES-1:0]                 dispatch_dest_valid,
    input  rob_pkg::arch_reg_t [`ROB_LANES-1:0]   dispatch_dest,
    output rob_pkg::rob_tag_t [`ROB_LANES-1:0]    alloc_tag,
    output logic [`ROB_LANES-1:0]                 map_valid,
    output rob_pkg::credit_t                      credits,
    // operand lookup
    input  rob_pkg::rob_tag_t [`ROB_LANES-1:0]    src_tag_a,
    input  rob_pkg::rob_tag_t [`ROB_LANES-1:0]    src_tag_b,
    output rob_pkg::word_t [`ROB_LANES-1:0]       src_value_a,
    output rob_pkg::word_t [`ROB_LANES-1:0]       src_value_b,
    output logic [`ROB_LANES-1:0]                 src_ready_a,
    output logic [`ROB_LANES-1:0]                 src_ready_b,
    // cdb
    input  logic [`ROB_LANES-1:0]                 complete_valid,
    input  rob_pkg::rob_tag_t [`ROB_LANES-1:0]    complete_tag,
    input  rob_pkg::word_t [`ROB_LANES-1:0]       complete_value,
    input  logic [`ROB_LANES-1:0]                 complete_taken,
    // retire
    input  logic                                  mem_busy,
    output logic [`ROB_LANES-1:0]                 retire_valid,
    output rob_pkg::rob_tag_t [`ROB_LANES-1:0]    retire_tag,
    output logic [`ROB_LANES-1:0]                 retire_dest_valid,
    output rob_pkg::arch_reg_t [`ROB_LANES-1:0]   retire_dest,
    output rob_pkg::word_t [`ROB_LANES-1:0]       retire_value,
    output logic [`ROB_LANES-1:0]                 retire_taken
);

    rob_alloc_if alloc_bus ();    // allocator -> table writes
    rob_head_if  head_bus ();     // head window, table <-> retire

    rob_alloc alloc_i (
        .clock               (clock),
        .reset               (reset),
        .squash              (squash),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_dest_valid (dispatch_dest_valid),
        .dispatch_dest       (dispatch_dest),
        .alloc_tag           (alloc_tag),
        .map_valid           (map_valid),
        .credits             (credits),
        .alloc               (alloc_bus.alloc_side)
    );

    rob_table table_i (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .src_tag_a      (src_tag_a),
        .src_tag_b      (src_tag_b),
        .src_value_a    (src_value_a),
        .src_value_b    (src_value_b),
        .src_ready_a    (src_ready_a),
        .src_ready_b    (src_ready_b),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .complete_value (complete_value),
        .complete_taken (complete_taken),
        .alloc          (alloc_bus.table_side),
        .head           (head_bus.table_side)
    );

    rob_retire retire_i (
        .clock             (clock),
        .reset             (reset),
        .squash            (squash),
        .mem_busy          (mem_busy),
        .retire_valid      (retire_valid),
        .retire_tag        (retire_tag),
        .retire_dest_valid (retire_dest_valid),
        .retire_dest       (retire_dest),
        .retire_value      (retire_value),
        .retire_taken      (retire_taken),
        .head              (head_bus.retire_side)
    );

endmodule

/* bench/rob_tb.sv */
`include "rob_params.svh"

module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WATCHDOG_NS = 6 * 300 * 8;    // six tests, 300 cycles each

    logic clock;
    logic reset;
    logic squash;
    logic mem_busy;
    logic [`ROB_LANES-1:0]                 dispatch_valid;
    rob_pkg::op_class_e [`ROB_LANES-1:0]   dispatch_op;
    logic [`ROB_LANES-1:0]                 dispatch_dest_valid;
    rob_pkg::arch_reg_t [`ROB_LANES-1:0]   dispatch_dest;
    rob_pkg::rob_tag_t [`ROB_LANES-1:0]    alloc_tag;
    logic [`ROB_LANES-1:0]                 map_valid;
    rob_pkg::credit_t                      credits;
    rob_pkg::rob_tag_t [`ROB_LANES-1:0]    src_tag_a;
    rob_pkg::rob_tag_t [`ROB_LANES-1:0]    src_tag_b;
    rob_pkg::word_t [`ROB_LANES-1:0]       src_value_a;
    rob_pkg::word_t [`ROB_LANES-1:0]       src_value_b;
    logic [`ROB_LANES-1:0]                 src_ready_a;
    logic [`ROB_LANES-1:0]                 src_ready_b;
    logic [`ROB_LANES-1:0]                 complete_valid;
    rob_pkg::rob_tag_t [`ROB_LANES-1:0]    complete_tag;
    rob_pkg::word_t [`ROB_LANES-1:0]       complete_value;
    logic [`ROB_LANES-1:0]                 complete_taken;
    logic [`ROB_LANES-1:0]                 retire_valid;
    rob_pkg::rob_tag_t [`ROB_LANES-1:0]    retire_tag;
    logic [`ROB_LANES-1:0]                 retire_dest_valid;
    rob_pkg::arch_reg_t [`ROB_LANES-1:0]   retire_dest;
    rob_pkg::word_t [`ROB_LANES-1:0]       retire_value;
    logic [`ROB_LANES-1:0]                 retire_taken;

    // reference model, indexed by tag
    rob_pkg::rob_tag_t   order_q [$];           // live tags, oldest first
    rob_pkg::rob_tag_t   model_tail;
    logic                ent_done  [`ROB_DEPTH];
    logic                ent_mem   [`ROB_DEPTH];
    logic                ent_taken [`ROB_DEPTH];
    logic                ent_dv    [`ROB_DEPTH];
    rob_pkg::arch_reg_t  ent_dest  [`ROB_DEPTH];
    rob_pkg::word_t      ent_value [`ROB_DEPTH];
    logic [`ROB_LANES-1:0] exp_map;             // lanes put this cycle that name a reg
    int                  errors;
    integer              seed;

    rob_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic rob_pkg::rob_tag_t offset_tag(input rob_pkg::rob_tag_t base, input int off);
        return base + rob_pkg::rob_tag_t'(off);   // wraps at depth
    endfunction

    // group the head should retire now, from the serialising rule
    function automatic int retire_count();
        int n = 0;
        logic mem_seen;
        rob_pkg::rob_tag_t t;
        mem_seen = 1'b0;
        for (int i = 0; i < `ROB_LANES; i++) begin
            if (i >= order_q.size()) break;
            t = order_q[i];
            if (!ent_done[t]) break;
            if ((ent_mem[t] || ent_taken[t]) && (mem_busy || mem_seen)) break;
            n++;
            mem_seen = mem_seen | ent_mem[t];
        end
        return n;
    endfunction

    // check outputs mid cycle, then step the model across the edge
    task automatic advance();
        int n;
        int free;
        rob_pkg::rob_tag_t t;
        @(negedge clock);
        n = retire_count();
        free = `ROB_DEPTH - order_q.size();
        check("credits", 32'(free > `ROB_LANES ? `ROB_LANES : free), 32'(credits));
        for (int i = 0; i < `ROB_LANES; i++) begin
            check($sformatf("retire_valid[%0d]", i), 32'(i < n), 32'(retire_valid[i]));
            if (i < n) begin
                t = order_q[i];
                check($sformatf("retire_tag[%0d]", i), 32'(t), 32'(retire_tag[i]));
                check($sformatf("retire_value[%0d]", i), ent_value[t], retire_value[i]);
                check($sformatf("retire_dest_valid[%0d]", i), 32'(ent_dv[t]),
                      32'(retire_dest_valid[i]));
                if (ent_dv[t])
                    check($sformatf("retire_dest[%0d]", i), 32'(ent_dest[t]),
                          32'(retire_dest[i]));
                check($sformatf("retire_taken[%0d]", i), 32'(ent_taken[t]),
                      32'(retire_taken[i]));
            end
            check($sformatf("alloc_tag[%0d]", i), 32'(offset_tag(model_tail, i)),
                  32'(alloc_tag[i]));
            check($sformatf("map_valid[%0d]", i), 32'(exp_map[i]), 32'(map_valid[i]));
            check($sformatf("src_ready_a[%0d]", i), 32'(ent_done[src_tag_a[i]]),
                  32'(src_ready_a[i]));
            check($sformatf("src_ready_b[%0d]", i), 32'(ent_done[src_tag_b[i]]),
                  32'(src_ready_b[i]));
            if (ent_done[src_tag_a[i]])
                check($sformatf("src_value_a[%0d]", i), ent_value[src_tag_a[i]], src_value_a[i]);
            if (ent_done[src_tag_b[i]])
                check($sformatf("src_value_b[%0d]", i), ent_value[src_tag_b[i]], src_value_b[i]);
        end
        @(posedge clock);
        if (squash) begin
            order_q.delete();    // everything in flight is dropped
            model_tail = '0;
            foreach (ent_done[k]) ent_done[k] = 1'b0;
        end else begin
            repeat (n) begin
                t = order_q.pop_front();
                ent_done[t] = 1'b0;
            end
            for (int i = 0; i < `ROB_LANES; i++) begin
                if (dispatch_valid[i]) begin
                    order_q.push_back(model_tail);
                    ent_mem[model_tail] = (dispatch_op[i] != rob_pkg::OP_ALU);
                    ent_dv[model_tail]  = dispatch_dest_valid[i];
                    ent_dest[model_tail] = dispatch_dest[i];
                    ent_done[model_tail] = 1'b0;
                    model_tail = offset_tag(model_tail, 1);
                end
            end
            for (int i = 0; i < `ROB_LANES; i++) begin
                if (complete_valid[i]) begin   // cdb writeback lands after retire clears
                    ent_done[complete_tag[i]]  = 1'b1;
                    ent_value[complete_tag[i]] = complete_value[i];
                    ent_taken[complete_tag[i]] = complete_taken[i];
                end
            end
        end
        #1;
        dispatch_valid = '0;    // one-shot lanes
        exp_map = '0;
        complete_valid = '0;
        squash = 1'b0;
    endtask

    task automatic put_lane(input int lane, input rob_pkg::op_class_e op, input logic dv,
                            input rob_pkg::arch_reg_t dest);
        dispatch_valid[lane]      = 1'b1;
        dispatch_op[lane]         = op;
        dispatch_dest_valid[lane] = dv;
        dispatch_dest[lane]       = dest;
        exp_map[lane]             = dv;   // map table hears only about named regs
    endtask

    task automatic put_complete(input int lane, input rob_pkg::rob_tag_t tag, input logic taken);
        complete_valid[lane] = 1'b1;
        complete_tag[lane]   = tag;
        complete_value[lane] = $random(seed);
        complete_taken[lane] = taken;
    endtask

    task automatic expect_retire(input logic [`ROB_LANES-1:0] mask);
        #1;
        check("retire_valid", 32'(mask), 32'(retire_valid));
    endtask

    task automatic drain(input int limit);
        int k = 0;
        while (order_q.size() > 0 && k < limit) begin
            advance();
            k++;
        end
        if (order_q.size() > 0) begin
            errors++;
            $display("retire stalled at %0d ns with %0d entries left", $time, order_q.size());
        end
    endtask

    task automatic test_reset();
        expect_retire('0);
        check("credits", 32'(`ROB_LANES), 32'(credits));
        for (int i = 0; i < `ROB_LANES; i++)
            check($sformatf("alloc_tag[%0d]", i), 32'(i), 32'(alloc_tag[i]));
        advance();
    endtask

    // fill with groups of 1, 2, 3 lanes, nothing completes
    task automatic test_fill();
        int lanes;
        int k = 0;
        while (order_q.size() < `ROB_DEPTH) begin
            lanes = (k % 3) + 1;
            if (lanes > `ROB_DEPTH - order_q.size()) lanes = `ROB_DEPTH - order_q.size();
            for (int i = 0; i < lanes; i++)
                put_lane(i, rob_pkg::OP_ALU, ((k + i) % 3) != 1, rob_pkg::arch_reg_t'(k + i));
            advance();
            k++;
        end
        #1;
        check("credits", 32'(0), 32'(credits));   // full one edge after the last entry
        advance();
    endtask

    // complete the full buffer out of order, retire must stay in order
    task automatic test_in_order();
        rob_pkg::rob_tag_t pend [$];
        pend = order_q;
        for (int k = 0; k < pend.size(); k++) begin
            put_complete(k % 3, pend[(k * 7) % pend.size()], 1'b0);   // stride 7 scrambles
            if (k % 3 == 2 || k == pend.size() - 1) advance();
        end
        drain(40);
    endtask

    task automatic test_operands();
        rob_pkg::rob_tag_t base;
        base = model_tail;
        for (int i = 0; i < `ROB_LANES; i++) begin
            put_lane(i, rob_pkg::OP_ALU, 1'b1, rob_pkg::arch_reg_t'(i + 7));
            src_tag_a[i] = offset_tag(base, i);
            src_tag_b[i] = offset_tag(base, 2 - i);
        end
        advance();
        #1;
        check("src_ready_a", 32'(0), 32'(src_ready_a));   // busy, not done
        check("src_ready_b", 32'(0), 32'(src_ready_b));
        for (int i = 0; i < `ROB_LANES; i++) put_complete(i, offset_tag(base, i), 1'b0);
        advance();
        #1;
        check("src_ready_a", 32'(3'b111), 32'(src_ready_a));
        for (int i = 0; i < `ROB_LANES; i++)
            check($sformatf("src_value_a[%0d]", i), ent_value[offset_tag(base, i)],
                  src_value_a[i]);
        drain(10);
    endtask

    task automatic test_serialise();
        rob_pkg::rob_tag_t base;
        mem_busy = 1'b1;   // load held at head
        base = model_tail;
        put_lane(0, rob_pkg::OP_LOAD, 1'b1, 5'd3);
        advance();
        put_complete(0, base, 1'b0);
        advance();
        repeat (4) begin
            expect_retire('0);
            advance();
        end
        mem_busy = 1'b0;
        expect_retire(3'b001);
        drain(10);
        // alu, store, load in one group
        base = model_tail;
        put_lane(0, rob_pkg::OP_ALU, 1'b1, 5'd1);
        put_lane(1, rob_pkg::OP_STORE, 1'b0, 5'd0);
        put_lane(2, rob_pkg::OP_LOAD, 1'b1, 5'd2);
        advance();
        for (int i = 0; i < `ROB_LANES; i++) put_complete(i, offset_tag(base, i), 1'b0);
        advance();
        expect_retire(3'b011);
        advance();
        expect_retire(3'b001);
        drain(10);
        // taken branch
        mem_busy = 1'b1;
        base = model_tail;
        put_lane(0, rob_pkg::OP_ALU, 1'b0, 5'd0);
        advance();
        put_complete(0, base, 1'b1);
        advance();
        repeat (3) begin
            expect_retire('0);
            advance();
        end
        mem_busy = 1'b0;
        expect_retire(3'b001);
        drain(10);
    endtask

    task automatic test_squash();
        rob_pkg::rob_tag_t base;
        base = model_tail;
        for (int i = 0; i < `ROB_LANES; i++) put_lane(i, rob_pkg::OP_ALU, 1'b1, 5'd9);
        advance();
        for (int i = 0; i < `ROB_LANES; i++) put_lane(i, rob_pkg::OP_LOAD, 1'b1, 5'd4);
        put_complete(1, offset_tag(base, 1), 1'b0);   // head not done, nothing retires
        advance();
        squash = 1'b1;
        advance();
        expect_retire('0);
        check("credits", 32'(`ROB_LANES), 32'(credits));
        for (int i = 0; i < `ROB_LANES; i++)
            check($sformatf("alloc_tag[%0d]", i), 32'(i), 32'(alloc_tag[i]));
        repeat (3) advance();
        put_lane(0, rob_pkg::OP_ALU, 1'b1, 5'd6);
        advance();
        put_complete(0, '0, 1'b0);
        advance();
        expect_retire(3'b001);
        check("retire_tag[0]", 32'(0), 32'(retire_tag[0]));
        drain(10);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        errors = 0;
        seed = 32'h6ab5;
        reset = 1'b1;
        squash = 1'b0;
        mem_busy = 1'b0;
        dispatch_valid = '0;
        dispatch_op = {`ROB_LANES{rob_pkg::OP_ALU}};
        dispatch_dest_valid = '0;
        dispatch_dest = '0;
        exp_map = '0;
        src_tag_a = '0;
        src_tag_b = '0;
        complete_valid = '0;
        complete_tag = '0;
        complete_value = '0;
        complete_taken = '0;
        model_tail = '0;
        foreach (ent_done[k]) ent_done[k] = 1'b0;
        repeat (5) @(posedge clock);
        #1 reset = 1'b0;
        test_reset();
        test_fill();
        test_in_order();
        test_operands();
        test_serialise();
        test_squash();
        $display("rob_tb finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/rob_pkg.sv
logic/rob_ifs.sv
logic/rob_alloc.sv
logic/rob_table.sv
logic/rob_retire.sv
logic/rob_top.sv
bench/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rob_tb -f sources.f -o rob_sim &&
./obj_dir/rob_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }
